// File: bench/rv32iCoreTb.sv
`include "coreDefs.svh"

module rv32iCoreTb;

	typedef enum int {
		opLui, opAddi, opSlti, opSltiu, opXori, opOri, opAndi, opSlli, opSrli, opSrai,
		opAdd, opSub, opSll, opSlt, opSltu, opXor, opSrl, opSra, opOr, opAnd, opHalt
	} operation_t;

	localparam int rowCount = 21;
	localparam int watchdogCycles = rowCount * 40 + 200;
	localparam logic [31:0] resetPc = 32'h0000_0100;
	localparam logic [31:0] programBase = 32'h0000_1000;
	localparam logic [15:0] pcAddress = {`MGMT_REGION_SYSTEM, `MGMT_PC_OFFSET};
	localparam logic [15:0] irAddress = {`MGMT_REGION_SYSTEM, `MGMT_IR_OFFSET};

	logic clk = 1'b0;
	logic rst;
	isaPkg::word_t resetProgramCounterAddress;
	isaPkg::word_t instructionAddress;
	logic instructionEnable;
	isaPkg::instr_t instructionData;
	logic instructionBusy;
	logic managementRun;
	logic managementWriteEnable;
	controlPkg::byteSel_t managementByteSelect;
	controlPkg::mgmtAddr_t managementAddress;
	isaPkg::word_t managementWriteData;
	isaPkg::word_t managementReadData;
	logic probeState;
	isaPkg::word_t probeProgramCounter;

	// Program table, one instruction per row
	operation_t rowOp [0:rowCount-1];
	int rowRd [0:rowCount-1];
	int rowRs1 [0:rowCount-1];
	int rowSrc2 [0:rowCount-1];
	logic [31:0] rowExpected [0:rowCount-1];
	logic [31:0] programWords [0:rowCount-1];
	logic [31:0] regModel [0:31];
	int rowIndex = 0;
	int passCount = 0;
	int failCount = 0;
	integer seed = 82;

	rv32iCore rv32iCore_inst (.*);

	always #2 clk = ~clk;

	function automatic logic [31:0] encodeInstruction(input operation_t op, input int rd,
		input int rs1, input int src2);
		logic [4:0] d;
		logic [4:0] s1;
		logic [4:0] low;
		d = rd[4:0];
		s1 = rs1[4:0];
		low = src2[4:0];
		case (op)
			opLui: return {src2[19:0], d, `OPC_LUI};
			opAddi: return {src2[11:0], s1, `F3_ADD, d, `OPC_OP_IMM};
			opSlti: return {src2[11:0], s1, `F3_SLT, d, `OPC_OP_IMM};
			opSltiu: return {src2[11:0], s1, `F3_SLTU, d, `OPC_OP_IMM};
			opXori: return {src2[11:0], s1, `F3_XOR, d, `OPC_OP_IMM};
			opOri: return {src2[11:0], s1, `F3_OR, d, `OPC_OP_IMM};
			opAndi: return {src2[11:0], s1, `F3_AND, d, `OPC_OP_IMM};
			opSlli: return {7'b0000000, low, s1, `F3_SLL, d, `OPC_OP_IMM};
			opSrli: return {7'b0000000, low, s1, `F3_SR, d, `OPC_OP_IMM};
			opSrai: return {7'b0100000, low, s1, `F3_SR, d, `OPC_OP_IMM};
			opAdd: return {7'b0000000, low, s1, `F3_ADD, d, `OPC_OP};
			opSub: return {7'b0100000, low, s1, `F3_ADD, d, `OPC_OP};
			opSll: return {7'b0000000, low, s1, `F3_SLL, d, `OPC_OP};
			opSlt: return {7'b0000000, low, s1, `F3_SLT, d, `OPC_OP};
			opSltu: return {7'b0000000, low, s1, `F3_SLTU, d, `OPC_OP};
			opXor: return {7'b0000000, low, s1, `F3_XOR, d, `OPC_OP};
			opSrl: return {7'b0000000, low, s1, `F3_SR, d, `OPC_OP};
			opSra: return {7'b0100000, low, s1, `F3_SR, d, `OPC_OP};
			opOr: return {7'b0000000, low, s1, `F3_OR, d, `OPC_OP};
			opAnd: return {7'b0000000, low, s1, `F3_AND, d, `OPC_OP};
			default: return 32'h0;
		endcase
	endfunction

	// RV32I result for operand a and second operand b
	function automatic logic [31:0] referenceResult(input operation_t op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			opLui: return b << 12;
			opAddi, opAdd: return a + b;
			opSub: return a - b;
			opSlti, opSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			opSltiu, opSltu: return (a < b) ? 32'd1 : 32'd0;
			opXori, opXor: return a ^ b;
			opOri, opOr: return a | b;
			opAndi, opAnd: return a & b;
			opSlli, opSll: return a << b[4:0];
			opSrli, opSrl: return a >> b[4:0];
			opSrai, opSra: return $signed(a) >>> b[4:0];
			default: return 32'h0;
		endcase
	endfunction

	function automatic logic [15:0] registerAddress(input int index);
		return {`MGMT_REGION_REGISTERS, 7'h00, index[4:0], 2'b00};
	endfunction

	function automatic logic [31:0] fetchWord(input logic [31:0] address);
		logic [31:0] offset;
		offset = (address - programBase) >> 2;
		if (address < programBase || offset >= rowCount)
			return 32'h0;
		return programWords[offset[4:0]];
	endfunction

	task automatic addRow(input operation_t op, input int rd, input int rs1, input int src2);
		rowOp[rowIndex] = op;
		rowRd[rowIndex] = rd;
		rowRs1[rowIndex] = rs1;
		rowSrc2[rowIndex] = src2;
		rowIndex++;
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch %s: got %h, expected %h", name, actual, expected);
			failCount++;
		end else begin
			$display("ok %s = %h", name, actual);
			passCount++;
		end
	endtask

	task automatic checkCondition(input string description, input logic condition);
		if (condition !== 1'b1) begin
			$display("Failed: %s", description);
			failCount++;
		end else begin
			$display("ok %s", description);
			passCount++;
		end
	endtask

	task automatic writeManagement(input logic [15:0] address, input logic [31:0] data);
		@(negedge clk);
		managementAddress = address;
		managementWriteData = data;
		managementByteSelect = 4'hF;
		managementWriteEnable = 1'b1;
		@(negedge clk);
		managementWriteEnable = 1'b0;
	endtask

	task automatic readManagement(input logic [15:0] address, input logic [3:0] byteSelect,
		output logic [31:0] data);
		@(negedge clk);
		managementWriteEnable = 1'b0;
		managementAddress = address;
		managementByteSelect = byteSelect;
		#1;
		data = managementReadData;
	endtask

	// Instruction memory with random wait states
	initial begin
		logic [31:0] draw;
		instructionBusy = 1'b1;
		instructionData = '0;
		forever begin
			@(negedge clk);
			draw = $random(seed);
			instructionBusy = draw[0];
			instructionData = fetchWord(instructionAddress);
		end
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] readback;
		logic [31:0] operandB;
		rst = 1'b1;
		resetProgramCounterAddress = resetPc;
		managementRun = 1'b0;
		managementWriteEnable = 1'b0;
		managementByteSelect = 4'hF;
		managementAddress = '0;
		managementWriteData = '0;
		repeat (4) @(negedge clk);
		rst = 1'b0;

		checkCondition("core halted after reset", probeState == 1'b0);
		checkCondition("no fetch request after reset", instructionEnable == 1'b0);
		readManagement(pcAddress, 4'hF, readback);
		checkValue("pc after reset", readback, resetPc);

		// Fill pattern over the whole register index
		regModel[0] = '0;
		for (int i = 1; i < 32; i++) begin
			regModel[i] = (i * 32'h0101_0101) ^ 32'h5A3C_C3A5 ^ (i << 27);
			writeManagement(registerAddress(i), regModel[i]);
		end
		for (int i = 1; i < 32; i++) begin
			readManagement(registerAddress(i), 4'hF, readback);
			checkValue($sformatf("x%0d", i), readback, regModel[i]);
		end
		writeManagement(registerAddress(0), 32'hFFFF_FFFF);
		readManagement(registerAddress(0), 4'hF, readback);
		checkValue("x0", readback, 32'h0);
		readManagement(registerAddress(5), 4'b0101, readback);
		checkValue("x5 bytes 0 and 2", readback, regModel[5] & 32'h00FF_00FF);
		readManagement(16'h8000, 4'hF, readback);
		checkValue("unmapped address", readback, 32'hFFFF_FFFF);

		addRow(opLui, 10, 0, 32'h80001);
		addRow(opAddi, 11, 10, -5);
		addRow(opSlti, 12, 11, 3);
		addRow(opSltiu, 13, 11, 3);
		addRow(opXori, 14, 12, -1);
		addRow(opOri, 15, 14, 32'h0F0);
		addRow(opAndi, 16, 15, 32'h7FF);
		addRow(opSlli, 17, 16, 7);
		addRow(opSrli, 18, 10, 4);
		addRow(opSrai, 19, 10, 4);
		addRow(opAdd, 20, 19, 18);
		addRow(opSub, 21, 20, 3);
		addRow(opSll, 22, 21, 11);
		addRow(opSlt, 23, 22, 17);
		addRow(opSltu, 24, 22, 23);
		addRow(opXor, 25, 24, 21);
		addRow(opSrl, 26, 25, 2);
		addRow(opSra, 27, 21, 26);
		addRow(opOr, 28, 27, 26);
		addRow(opAnd, 29, 28, 31);
		addRow(opHalt, 0, 0, 0);

		// Encode each row and follow its effect on the register model
		for (int r = 0; r < rowCount; r++) begin
			programWords[r] = encodeInstruction(rowOp[r], rowRd[r], rowRs1[r], rowSrc2[r]);
			if (rowOp[r] == opLui)
				operandB = rowSrc2[r];
			else if (rowOp[r] >= opAdd)
				operandB = regModel[rowSrc2[r][4:0]];
			else
				operandB = {{20{rowSrc2[r][11]}}, rowSrc2[r][11:0]};
			if (rowOp[r] != opHalt) begin
				rowExpected[r] = referenceResult(rowOp[r], regModel[rowRs1[r]], operandB);
				regModel[rowRd[r]] = rowExpected[r];
			end
		end

		writeManagement(pcAddress, programBase);
		@(negedge clk);
		managementRun = 1'b1;
		while (!probeState)
			@(negedge clk);
		while (probeState)
			@(negedge clk);
		managementRun = 1'b0;
		repeat (2) @(negedge clk);
		for (int r = 0; r < rowCount - 1; r++) begin
			readManagement(registerAddress(rowRd[r]), 4'hF, readback);
			checkValue($sformatf("row %0d x%0d", r, rowRd[r]), readback, rowExpected[r]);
		end

		readManagement(pcAddress, 4'hF, readback);
		checkValue("pc after halt", readback, programBase + 4 * (rowCount - 1));
		checkValue("probeProgramCounter after halt", probeProgramCounter,
			programBase + 4 * (rowCount - 1));
		readManagement(irAddress, 4'hF, readback);
		checkValue("instruction register after halt", readback, 32'h0);

		// Core restarts on the zero word and halts again
		@(negedge clk);
		managementRun = 1'b1;
		managementAddress = registerAddress(12);
		managementWriteData = 32'hA5A5_0F0F;
		managementWriteEnable = 1'b1;
		while (!probeState)
			@(negedge clk);
		while (probeState)
			@(negedge clk);
		managementWriteEnable = 1'b0;
		managementRun = 1'b0;
		repeat (2) @(negedge clk);
		readManagement(registerAddress(12), 4'hF, readback);
		checkValue("x12 after write with run high", readback, regModel[12]);

		$display("Checks passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: bench/rv32iCore_assert.sv
module rv32iCore_assert (
	input logic clk,
	input logic rst,
	input isaPkg::word_t instructionAddress,
	input logic instructionEnable,
	input logic instructionBusy,
	input controlPkg::coreState_t state,
	input logic writebackEnable,
	input isaPkg::regAddr_t writebackAddress
);

	// Stalled request holds
	assert property (@(posedge clk) disable iff (rst)
		instructionEnable && instructionBusy |=> instructionEnable && $stable(instructionAddress))
		else $error("instruction request changed while memory was busy");

	assert property (@(posedge clk) disable iff (rst)
		instructionEnable |-> state == controlPkg::stateExecute)
		else $error("instruction request made while halted");

	assert property (@(posedge clk) disable iff (rst)
		writebackEnable |-> writebackAddress != '0)
		else $error("writeback targets x0");

endmodule

bind rv32iCore rv32iCore_assert coreChecks (
	.clk(clk),
	.rst(rst),
	.instructionAddress(instructionAddress),
	.instructionEnable(instructionEnable),
	.instructionBusy(instructionBusy),
	.state(control.state),
	.writebackEnable(writebackEnable),
	.writebackAddress(writebackAddress)
);

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rv32iCore.f --top-module rv32iCoreTb -o rv32iCoreSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/rv32iCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: rv32iCore.f
+incdir+source
source/isaPkg.sv
source/controlPkg.sv
source/registerFile.sv
source/fetchStage.sv
source/executeStage.sv
source/coreControl.sv
source/rv32iCore.sv
bench/rv32iCore_assert.sv
bench/rv32iCoreTb.sv

// File: source/controlPkg.sv
package controlPkg;

	typedef enum logic {
		stateHalt = 1'b0,
		stateExecute = 1'b1
	} coreState_t;

	typedef logic [15:0] mgmtAddr_t;

	// One bit per byte lane of a management word
	typedef logic [3:0] byteSel_t;

endpackage

// File: source/coreControl.sv
`include "coreDefs.svh"

module coreControl (
	input logic clk,
	input logic rst,
	input logic managementRun,
	input logic managementWriteEnable,
	input controlPkg::byteSel_t managementByteSelect,
	input controlPkg::mgmtAddr_t managementAddress,
	input logic fetchComplete,
	input logic fetchValid,
	input logic haltRequest,
	input isaPkg::word_t programCounter,
	input isaPkg::instr_t fetchedInstruction,
	input isaPkg::word_t managementRegisterData,
	output isaPkg::word_t managementReadData,
	output isaPkg::regAddr_t managementRegisterAddress,
	output logic managementRegisterWrite,
	output logic managementPcWrite,
	output logic stepPipe,
	output logic executeActive
);

	controlPkg::coreState_t state;
	logic previousRun;
	logic selectPc;
	logic selectIr;
	logic selectRegister;
	logic writeAllowed;
	logic readValid;
	isaPkg::word_t selectedData;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= controlPkg::stateHalt;
			previousRun <= 1'b0;
		end else begin
			previousRun <= managementRun;
			case (state)
				controlPkg::stateHalt: begin
					// Start only on a fresh rising edge of run
					if (managementRun && !previousRun)
						state <= controlPkg::stateExecute;
				end
				controlPkg::stateExecute: begin
					if (haltRequest || !managementRun)
						state <= controlPkg::stateHalt;
				end
				default: state <= controlPkg::stateHalt;
			endcase
		end
	end

	// Drops in the cycle a halt is requested, so nothing more is fetched
	assign executeActive = (state == controlPkg::stateExecute) && managementRun && !haltRequest;
	assign stepPipe = executeActive && (fetchComplete || fetchValid);

	// Address decode
	assign selectPc = (managementAddress[15:14] == `MGMT_REGION_SYSTEM)
		&& (managementAddress[13:0] == `MGMT_PC_OFFSET);
	assign selectIr = (managementAddress[15:14] == `MGMT_REGION_SYSTEM)
		&& (managementAddress[13:0] == `MGMT_IR_OFFSET);
	assign selectRegister = (managementAddress[15:14] == `MGMT_REGION_REGISTERS)
		&& (managementAddress[13:7] == 7'h00);
	assign managementRegisterAddress = managementAddress[6:2];

	assign writeAllowed = managementWriteEnable && !managementRun
		&& (state == controlPkg::stateHalt);
	assign managementPcWrite = writeAllowed && selectPc;
	assign managementRegisterWrite = writeAllowed && selectRegister;

	assign readValid = !managementRun && !managementWriteEnable;

	always_comb begin
		selectedData = '1;
		if (readValid) begin
			if (selectPc)
				selectedData = programCounter;
			else if (selectIr)
				selectedData = fetchedInstruction;
			else if (selectRegister)
				selectedData = managementRegisterData;
		end
		// Unselected bytes read zero
		for (int i = 0; i < 4; i++) begin
			managementReadData[8*i +: 8] = managementByteSelect[i] ? selectedData[8*i +: 8] : 8'h00;
		end
	end

endmodule

// File: source/coreDefs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath widths
`define XLEN 32
`define REG_ADDR_BITS 5

// Major opcodes of the kept subset
`define OPC_LUI 7'b0110111
`define OPC_OP_IMM 7'b0010011
`define OPC_OP 7'b0110011

// funct3 codes shared by OP and OP-IMM
`define F3_ADD 3'b000
`define F3_SLL 3'b001
`define F3_SLT 3'b010
`define F3_SLTU 3'b011
`define F3_XOR 3'b100
`define F3_SR 3'b101
`define F3_OR 3'b110
`define F3_AND 3'b111

// Management address map, region in bits 15:14
`define MGMT_REGION_SYSTEM 2'b00
`define MGMT_REGION_REGISTERS 2'b01

// Offsets inside the system region
`define MGMT_PC_OFFSET 14'h0000
`define MGMT_IR_OFFSET 14'h0010

`endif

// File: source/executeStage.sv
`include "coreDefs.svh"

module executeStage (
	input logic clk,
	input logic rst,
	input logic stepPipe,
	input logic fetchValid,
	input isaPkg::instr_t fetchedInstruction,
	input isaPkg::word_t fetchedPc,
	output isaPkg::regAddr_t rs1Address,
	output isaPkg::regAddr_t rs2Address,
	input isaPkg::word_t rs1Data,
	input isaPkg::word_t rs2Data,
	output isaPkg::regAddr_t writebackAddress,
	output isaPkg::word_t writebackData,
	output logic writebackEnable,
	output logic haltRequest,
	output isaPkg::word_t executePc
);

	isaPkg::opcode_t opcode;
	isaPkg::regAddr_t rd;
	logic [2:0] funct3;
	logic [6:0] funct7;
	isaPkg::word_t immI;
	isaPkg::word_t immU;
	isaPkg::word_t result;
	logic isValid;

	function automatic isaPkg::word_t aluResult(input isaPkg::word_t a, input isaPkg::word_t b,
		input logic [2:0] op, input logic alt);
		isaPkg::word_t value;
		value = '0;
		case (op)
			`F3_ADD: value = alt ? a - b : a + b;
			`F3_SLL: value = a << b[4:0];
			`F3_SLT: value[0] = $signed(a) < $signed(b);
			`F3_SLTU: value[0] = a < b;
			`F3_XOR: value = a ^ b;
			`F3_SR: begin
				if (alt)
					value = $signed(a) >>> b[4:0];
				else
					value = a >> b[4:0];
			end
			`F3_OR: value = a | b;
			default: value = a & b;
		endcase
		return value;
	endfunction

	// Field extraction
	assign opcode = fetchedInstruction[6:0];
	assign rd = fetchedInstruction[11:7];
	assign funct3 = fetchedInstruction[14:12];
	assign funct7 = fetchedInstruction[31:25];
	assign rs1Address = fetchedInstruction[19:15];
	assign rs2Address = fetchedInstruction[24:20];
	assign immI = isaPkg::word_t'($signed(fetchedInstruction[31:20]));
	assign immU = {fetchedInstruction[31:12], 12'b0};

	always_comb begin
		isValid = 1'b0;
		result = '0;
		case (opcode)
			`OPC_LUI: begin
				isValid = 1'b1;
				result = immU;
			end
			`OPC_OP_IMM: begin
				case (funct3)
					`F3_SLL: isValid = funct7 == 7'b0000000;
					`F3_SR: isValid = funct7 == 7'b0000000 || funct7 == 7'b0100000;
					default: isValid = 1'b1;
				endcase
				// ADDI never subtracts, bit 30 only selects SRAI
				result = aluResult(rs1Data, immI, funct3, funct3 == `F3_SR && funct7[5]);
			end
			`OPC_OP: begin
				isValid = funct7 == 7'b0000000
					|| (funct7 == 7'b0100000 && (funct3 == `F3_ADD || funct3 == `F3_SR));
				result = aluResult(rs1Data, rs2Data, funct3, funct7[5]);
			end
			default: isValid = 1'b0;
		endcase
	end

	assign haltRequest = fetchValid && !isValid;
	assign executePc = fetchedPc;

	// Writes to x0 are dropped here
	always_ff @(posedge clk) begin
		if (rst)
			writebackEnable <= 1'b0;
		else
			writebackEnable <= stepPipe && fetchValid && isValid && (rd != '0);
	end

	always_ff @(posedge clk) begin
		if (stepPipe) begin
			writebackAddress <= rd;
			writebackData <= result;
		end
	end

endmodule

// File: source/fetchStage.sv
module fetchStage (
	input logic clk,
	input logic rst,
	input isaPkg::word_t resetProgramCounterAddress,
	input logic stepPipe,
	input logic executeActive,
	input logic managementPcWrite,
	input isaPkg::word_t managementWriteData,
	input isaPkg::word_t haltPc,
	output isaPkg::word_t instructionAddress,
	output logic instructionEnable,
	input isaPkg::instr_t instructionData,
	input logic instructionBusy,
	output logic fetchComplete,
	output logic fetchValid,
	output isaPkg::instr_t fetchedInstruction,
	output isaPkg::word_t fetchedPc,
	output isaPkg::word_t programCounter
);

	// Request held as long as busy is high
	assign instructionEnable = executeActive;
	assign instructionAddress = programCounter;
	assign fetchComplete = instructionEnable && !instructionBusy;

	always_ff @(posedge clk) begin
		if (rst) begin
			programCounter <= resetProgramCounterAddress;
			fetchValid <= 1'b0;
		end else if (executeActive) begin
			if (stepPipe)
				fetchValid <= fetchComplete;
			if (fetchComplete)
				programCounter <= programCounter + 4;
		end else if (managementPcWrite) begin
			programCounter <= managementWriteData;
		end else if (fetchValid) begin
			// Resume later from the instruction that never executed
			programCounter <= haltPc;
			fetchValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (stepPipe && fetchComplete) begin
			fetchedInstruction <= instructionData;
			fetchedPc <= programCounter;
		end
	end

endmodule

// File: source/isaPkg.sv
`include "coreDefs.svh"

package isaPkg;

	// Data word and address
	typedef logic [`XLEN-1:0] word_t;

	// Register index
	typedef logic [`REG_ADDR_BITS-1:0] regAddr_t;

	// Raw instruction word
	typedef logic [31:0] instr_t;

	// Major opcode field
	typedef logic [6:0] opcode_t;

endpackage

// File: source/registerFile.sv
`include "coreDefs.svh"

module registerFile (
	input logic clk,
	input logic rst,
	input isaPkg::regAddr_t rs1Address,
	input isaPkg::regAddr_t rs2Address,
	output isaPkg::word_t rs1Data,
	output isaPkg::word_t rs2Data,
	input isaPkg::regAddr_t writebackAddress,
	input isaPkg::word_t writebackData,
	input logic writebackEnable,
	input isaPkg::regAddr_t managementRegisterAddress,
	input logic managementRegisterWrite,
	input isaPkg::word_t managementWriteData,
	output isaPkg::word_t managementRegisterData
);

	// x0 has no storage
	isaPkg::word_t registers [1:(1 << `REG_ADDR_BITS) - 1];

	always_ff @(posedge clk) begin
		if (!rst) begin
			if (writebackEnable && writebackAddress != '0)
				registers[writebackAddress] <= writebackData;
			else if (managementRegisterWrite && managementRegisterAddress != '0)
				registers[managementRegisterAddress] <= managementWriteData;
		end
	end

	// Pending writeback wins over the stored value
	always_comb begin
		rs1Data = (rs1Address == '0) ? '0 : registers[rs1Address];
		if (writebackEnable && rs1Address != '0 && writebackAddress == rs1Address)
			rs1Data = writebackData;
		rs2Data = (rs2Address == '0) ? '0 : registers[rs2Address];
		if (writebackEnable && rs2Address != '0 && writebackAddress == rs2Address)
			rs2Data = writebackData;
	end

	assign managementRegisterData = (managementRegisterAddress == '0)
		? '0 : registers[managementRegisterAddress];

endmodule

// File: source/rv32iCore.sv
module rv32iCore (
	input logic clk,
	input logic rst,
	input isaPkg::word_t resetProgramCounterAddress,
	output isaPkg::word_t instructionAddress,
	output logic instructionEnable,
	input isaPkg::instr_t instructionData,
	input logic instructionBusy,
	input logic managementRun,
	input logic managementWriteEnable,
	input controlPkg::byteSel_t managementByteSelect,
	input controlPkg::mgmtAddr_t managementAddress,
	input isaPkg::word_t managementWriteData,
	output isaPkg::word_t managementReadData,
	output logic probeState,
	output isaPkg::word_t probeProgramCounter
);

	logic stepPipe;
	logic executeActive;
	logic fetchComplete;
	logic fetchValid;
	isaPkg::instr_t fetchedInstruction;
	isaPkg::word_t fetchedPc;
	isaPkg::word_t programCounter;
	isaPkg::word_t executePc;
	logic haltRequest;

	isaPkg::regAddr_t rs1Address;
	isaPkg::regAddr_t rs2Address;
	isaPkg::word_t rs1Data;
	isaPkg::word_t rs2Data;
	isaPkg::regAddr_t writebackAddress;
	isaPkg::word_t writebackData;
	logic writebackEnable;

	isaPkg::regAddr_t managementRegisterAddress;
	logic managementRegisterWrite;
	logic managementPcWrite;
	isaPkg::word_t managementRegisterData;

	coreControl control (
		.clk(clk),
		.rst(rst),
		.managementRun(managementRun),
		.managementWriteEnable(managementWriteEnable),
		.managementByteSelect(managementByteSelect),
		.managementAddress(managementAddress),
		.fetchComplete(fetchComplete),
		.fetchValid(fetchValid),
		.haltRequest(haltRequest),
		.programCounter(programCounter),
		.fetchedInstruction(fetchedInstruction),
		.managementRegisterData(managementRegisterData),
		.managementReadData(managementReadData),
		.managementRegisterAddress(managementRegisterAddress),
		.managementRegisterWrite(managementRegisterWrite),
		.managementPcWrite(managementPcWrite),
		.stepPipe(stepPipe),
		.executeActive(executeActive)
	);

	fetchStage fetch (
		.clk(clk),
		.rst(rst),
		.resetProgramCounterAddress(resetProgramCounterAddress),
		.stepPipe(stepPipe),
		.executeActive(executeActive),
		.managementPcWrite(managementPcWrite),
		.managementWriteData(managementWriteData),
		.haltPc(executePc),
		.instructionAddress(instructionAddress),
		.instructionEnable(instructionEnable),
		.instructionData(instructionData),
		.instructionBusy(instructionBusy),
		.fetchComplete(fetchComplete),
		.fetchValid(fetchValid),
		.fetchedInstruction(fetchedInstruction),
		.fetchedPc(fetchedPc),
		.programCounter(programCounter)
	);

	executeStage execute (
		.clk(clk),
		.rst(rst),
		.stepPipe(stepPipe),
		.fetchValid(fetchValid),
		.fetchedInstruction(fetchedInstruction),
		.fetchedPc(fetchedPc),
		.rs1Address(rs1Address),
		.rs2Address(rs2Address),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.writebackAddress(writebackAddress),
		.writebackData(writebackData),
		.writebackEnable(writebackEnable),
		.haltRequest(haltRequest),
		.executePc(executePc)
	);

	registerFile registers (
		.clk(clk),
		.rst(rst),
		.rs1Address(rs1Address),
		.rs2Address(rs2Address),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.writebackAddress(writebackAddress),
		.writebackData(writebackData),
		.writebackEnable(writebackEnable),
		.managementRegisterAddress(managementRegisterAddress),
		.managementRegisterWrite(managementRegisterWrite),
		.managementWriteData(managementWriteData),
		.managementRegisterData(managementRegisterData)
	);

	// Probes
	assign probeState = executeActive;
	assign probeProgramCounter = executePc;

endmodule
